//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module rv_core

sim:
	verilator --binary --timing -j 0 -f src.f --top-module tb_rv_core -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          f_valid,
	input  logic [rv_pkg::xlen-1:0]       f_pc,
	input  logic [rv_pkg::xlen-1:0]       f_instr,
	input  logic                          redirect,
	output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
	output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
	input  logic [rv_pkg::xlen-1:0]       rs1_data,
	input  logic [rv_pkg::xlen-1:0]       rs2_data,
	exec_bus.decode                       eb
);
	import rv_pkg::*;

	rv_instr_u       ins;
	instr_kind_e     kind;
	alu_op_e         alu_op;
	alu_op_e         arith_op;
	logic            a_is_pc;
	logic            b_is_imm;
	logic            is_op;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm;

	assign ins   = f_instr;
	assign is_op = (ins.r_view.opcode == OPC_OP);

	// lui reads x0 so the alu adds zero
	assign rs1_addr = (ins.r_view.opcode == OPC_LUI) ? '0 : ins.r_view.rs1;
	assign rs2_addr = ins.r_view.rs2;

	// ------------------------------
	// immediates
	// ------------------------------
	assign imm_i = {{20{ins.i_view.imm12[11]}}, ins.i_view.imm12};
	assign imm_u = {ins.i_view.imm12, ins.i_view.rs1, ins.i_view.funct3, 12'd0};
	assign imm_j = {{12{ins.i_view.imm12[11]}}, ins.i_view.rs1, ins.i_view.funct3,
		ins.i_view.imm12[0], ins.i_view.imm12[10:1], 1'b0};
	assign imm_b = {{20{ins.i_view.imm12[11]}}, ins.i_view.rd[0],
		ins.i_view.imm12[10:5], ins.i_view.rd[4:1], 1'b0};

	always_comb
	begin
		case (ins.r_view.funct3)
			3'b000:  arith_op = (is_op && ins.r_view.funct7[5]) ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = ins.r_view.funct7[5] ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb
	begin
		kind     = KIND_HALT;
		alu_op   = ALU_ADD;
		a_is_pc  = 1'b0;
		b_is_imm = 1'b0;
		imm      = imm_i;
		case (ins.r_view.opcode)
			OPC_LUI:
			begin
				kind     = KIND_ALU;
				b_is_imm = 1'b1;
				imm      = imm_u;
			end
			OPC_AUIPC:
			begin
				kind     = KIND_ALU;
				a_is_pc  = 1'b1;
				b_is_imm = 1'b1;
				imm      = imm_u;
			end
			OPC_JAL:
			begin
				kind = KIND_JUMP;
				imm  = imm_j;
			end
			OPC_JALR:
				kind = KIND_JALR;
			OPC_BRANCH:
			begin
				if (ins.r_view.funct3[2:1] != 2'b01)   // 010 and 011 are reserved
					kind = KIND_BRANCH;
				imm = imm_b;
			end
			OPC_OP_IMM:
			begin
				kind     = KIND_ALU;
				alu_op   = arith_op;
				b_is_imm = 1'b1;
			end
			OPC_OP:
			begin
				if (ins.r_view.funct7 == 7'h00 || ins.r_view.funct7 == 7'h20)
					kind = KIND_ALU;
				alu_op = arith_op;
			end
			OPC_SYSTEM:
				kind = KIND_HALT;   // ecall, ebreak
			default:
				kind = KIND_HALT;
		endcase
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			eb.valid <= 1'b0;
		else
			eb.valid <= f_valid && !redirect;   // squash on redirect
	end

	always_ff @(posedge clk)
	begin
		if (f_valid)
		begin
			eb.pc        <= f_pc;
			eb.kind      <= kind;
			eb.alu_op    <= alu_op;
			eb.a_is_pc   <= a_is_pc;
			eb.b_is_imm  <= b_is_imm;
			eb.operand_a <= rs1_data;
			eb.operand_b <= rs2_data;
			eb.imm       <= imm;
			eb.rd        <= ins.r_view.rd;
			eb.funct3    <= ins.r_view.funct3;
		end
	end

endmodule

//--- exec_bus.sv
`timescale 1ns/1ps

interface exec_bus;
	import rv_pkg::*;

	logic                  valid;
	logic [xlen-1:0]       pc;
	instr_kind_e           kind;
	alu_op_e               alu_op;
	logic                  a_is_pc;    // auipc
	logic                  b_is_imm;
	logic [xlen-1:0]       operand_a;  // rs1 value
	logic [xlen-1:0]       operand_b;  // rs2 value
	logic [xlen-1:0]       imm;
	logic [reg_addr_w-1:0] rd;
	logic [2:0]            funct3;     // branch condition

	modport decode (
		output valid, pc, kind, alu_op, a_is_pc, b_is_imm,
		output operand_a, operand_b, imm, rd, funct3
	);

	modport execute (
		input valid, pc, kind, alu_op, a_is_pc, b_is_imm,
		input operand_a, operand_b, imm, rd, funct3
	);

endinterface

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                          clk,
	input  logic                          rst,
	exec_bus.execute                      eb,
	output logic                          wr_en,
	output logic [rv_pkg::reg_addr_w-1:0] wr_addr,
	output logic [rv_pkg::xlen-1:0]       wr_data,
	output logic                          redirect,
	output logic [rv_pkg::xlen-1:0]       redirect_pc,
	output logic                          halted,
	output logic                          retire_valid,
	output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
	output logic [rv_pkg::xlen-1:0]       retire_data
);
	import rv_pkg::*;

	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] alu_res;
	logic [xlen-1:0] link;
	logic [xlen-1:0] jalr_sum;
	logic [xlen-1:0] target;
	logic            take;
	logic            br_taken;
	logic            is_jump;
	logic            jumps;
	logic            misaligned;

	// the slot after a redirect is wrong-path
	assign take = eb.valid && !redirect && !halted;
	assign op_a = eb.a_is_pc ? eb.pc : eb.operand_a;
	assign op_b = eb.b_is_imm ? eb.imm : eb.operand_b;

	always_comb
	begin
		case (eb.alu_op)
			ALU_SUB:  alu_res = op_a - op_b;
			ALU_AND:  alu_res = op_a & op_b;
			ALU_OR:   alu_res = op_a | op_b;
			ALU_XOR:  alu_res = op_a ^ op_b;
			ALU_SLL:  alu_res = op_a << op_b[4:0];
			ALU_SRL:  alu_res = op_a >> op_b[4:0];
			ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
			ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: alu_res = {31'd0, op_a < op_b};
			default:  alu_res = op_a + op_b;
		endcase
	end

	// ------------------------------
	// branches and jumps
	// ------------------------------
	always_comb
	begin
		case (eb.funct3)
			3'b000:  br_taken = eb.operand_a == eb.operand_b;
			3'b001:  br_taken = eb.operand_a != eb.operand_b;
			3'b100:  br_taken = $signed(eb.operand_a) < $signed(eb.operand_b);
			3'b101:  br_taken = $signed(eb.operand_a) >= $signed(eb.operand_b);
			3'b110:  br_taken = eb.operand_a < eb.operand_b;
			default: br_taken = eb.operand_a >= eb.operand_b;   // bgeu
		endcase
	end

	assign link       = eb.pc + instr_bytes;
	assign jalr_sum   = eb.operand_a + eb.imm;
	assign target     = (eb.kind == KIND_JALR) ? {jalr_sum[xlen-1:1], 1'b0} : eb.pc + eb.imm;
	assign is_jump    = (eb.kind == KIND_JUMP) || (eb.kind == KIND_JALR);
	assign jumps      = is_jump || (eb.kind == KIND_BRANCH && br_taken);
	assign misaligned = target[1];   // stops the core like an illegal op

	assign wr_en   = take && eb.rd != '0 &&
		(eb.kind == KIND_ALU || (is_jump && !misaligned));
	assign wr_addr = eb.rd;
	assign wr_data = (eb.kind == KIND_ALU) ? alu_res : link;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			redirect     <= 1'b0;
			halted       <= 1'b0;
			retire_valid <= 1'b0;
		end
		else
		begin
			redirect     <= take && jumps && !misaligned;
			retire_valid <= wr_en;
			if (take && (eb.kind == KIND_HALT || (jumps && misaligned)))
				halted <= 1'b1;   // sticky
		end
	end

	always_ff @(posedge clk)
	begin
		redirect_pc <= target;
		if (wr_en)
		begin
			retire_rd   <= wr_addr;
			retire_data <= wr_data;
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		redirect |-> redirect_pc[1:0] == 2'b00);

	assert property (@(posedge clk) disable iff (!rst)
		halted |=> halted && !retire_valid);

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
	input  logic                    clk,
	input  logic                    rst,
	output logic [rv_pkg::xlen-1:0] araddr,
	output logic                    arvalid,
	input  logic                    arready,
	input  logic [rv_pkg::xlen-1:0] rdata,
	input  logic [1:0]              rresp,
	input  logic                    rvalid,
	output logic                    rready,
	input  logic                    redirect,
	input  logic [rv_pkg::xlen-1:0] redirect_pc,
	input  logic                    halted,
	output logic                    f_valid,
	output logic [rv_pkg::xlen-1:0] f_pc,
	output logic [rv_pkg::xlen-1:0] f_instr
);
	import rv_pkg::*;

	logic [xlen-1:0] pc;          // next address to request
	logic [xlen-1:0] issue_addr;
	logic            outstanding;
	logic            stale;
	logic            ar_hs;
	logic            r_hs;
	logic            busy_next;
	logic            issue;
	logic            deliver;

	assign rready     = outstanding;
	assign ar_hs      = arvalid && arready;
	assign r_hs       = rvalid && outstanding;
	assign busy_next  = arvalid || (outstanding && !r_hs);
	assign issue      = !busy_next && !halted;
	assign issue_addr = redirect ? redirect_pc : pc;
	assign deliver    = r_hs && !stale && !redirect && !halted;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			arvalid     <= 1'b1;     // first fetch right out of reset
			araddr      <= reset_pc;
			pc          <= reset_pc + instr_bytes;
			outstanding <= 1'b0;
			stale       <= 1'b0;
			f_valid     <= 1'b0;
		end
		else
		begin
			f_valid <= deliver;
			if (ar_hs)
			begin
				arvalid     <= 1'b0;
				outstanding <= 1'b1;
			end
			if (r_hs)
			begin
				outstanding <= 1'b0;
				stale       <= 1'b0;
			end
			else if (redirect && (arvalid || outstanding))
				stale <= 1'b1;   // wrong-path read still in flight
			if (issue)
			begin
				arvalid <= 1'b1;
				araddr  <= issue_addr;
				pc      <= issue_addr + instr_bytes;
			end
			else if (redirect)
				pc <= redirect_pc;
		end
	end

	always_ff @(posedge clk)
	begin
		if (deliver)
		begin
			f_pc    <= araddr;
			f_instr <= (rresp != 2'b00) ? '0 : rdata;   // error reads decode as illegal
		end
	end

	assert property (@(posedge clk) disable iff (!rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          wr_en,
	input  logic [rv_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [rv_pkg::xlen-1:0]       wr_data,
	input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
	output logic [rv_pkg::xlen-1:0]       rs1_data,
	output logic [rv_pkg::xlen-1:0]       rs2_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [1:31];   // x0 is not stored

	function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wr_en && wr_addr == addr)
			return wr_data;   // same-cycle write wins
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		rs1_data = read_port(rs1_addr);
		rs2_data = read_port(rs2_addr);
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && wr_addr != '0)
			regs[wr_addr] <= wr_data;
	end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic                          clk,
	input  logic                          rst,
	output logic [rv_pkg::xlen-1:0]       araddr,
	output logic                          arvalid,
	input  logic                          arready,
	input  logic [rv_pkg::xlen-1:0]       rdata,
	input  logic [1:0]                    rresp,
	input  logic                          rvalid,
	output logic                          rready,
	output logic                          halted,
	output logic                          retire_valid,
	output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
	output logic [rv_pkg::xlen-1:0]       retire_data
);
	import rv_pkg::*;

	logic                  f_valid;
	logic [xlen-1:0]       f_pc;
	logic [xlen-1:0]       f_instr;
	logic                  redirect;
	logic [xlen-1:0]       redirect_pc;
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen-1:0]       rs1_data;
	logic [xlen-1:0]       rs2_data;
	logic                  wr_en;
	logic [reg_addr_w-1:0] wr_addr;
	logic [xlen-1:0]       wr_data;

	exec_bus eb ();

	// ------------------------------
	// pipeline stages
	// ------------------------------
	fetch_stage i_fetch (
		.clk, .rst,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.redirect, .redirect_pc, .halted,
		.f_valid, .f_pc, .f_instr
	);

	decode_stage i_decode (
		.clk, .rst,
		.f_valid, .f_pc, .f_instr,
		.redirect,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
		.eb (eb.decode)
	);

	reg_file i_reg_file (
		.clk, .rst,
		.wr_en, .wr_addr, .wr_data,
		.rs1_addr, .rs2_addr, .rs1_data, .rs2_data
	);

	execute_stage i_execute (
		.clk, .rst,
		.eb (eb.execute),
		.wr_en, .wr_addr, .wr_data,
		.redirect, .redirect_pc, .halted,
		.retire_valid, .retire_rd, .retire_data
	);

endmodule

//--- rv_pkg.sv
package rv_pkg;

	// ------------------------------
	// widths and fetch constants
	// ------------------------------
	localparam int xlen        = 32;
	localparam int reg_addr_w  = 5;
	localparam logic [xlen-1:0] reset_pc    = 32'h0000_0000;
	localparam logic [xlen-1:0] instr_bytes = 32'd4;

	// ------------------------------
	// major opcodes
	// ------------------------------
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} alu_op_e;

	typedef enum logic [2:0] {
		KIND_ALU    = 3'd0,
		KIND_JUMP   = 3'd1,
		KIND_JALR   = 3'd2,
		KIND_BRANCH = 3'd3,
		KIND_HALT   = 3'd4
	} instr_kind_e;

	// ------------------------------
	// instruction word views
	// ------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_view_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} rv_instr_u;

endpackage

//--- src.f
rv_pkg.sv
exec_bus.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input  logic reset_req,
	output logic clk,
	output logic rst
);
	int unsigned hold = 3;   // cycles left in reset

	initial clk = 1'b0;
	always #4 clk = ~clk;

	always @(posedge clk)
	begin
		if (reset_req)
			hold <= 3;
		else if (hold != 0)
			hold <= hold - 1;
	end

	assign rst = (hold == 0);

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	localparam int mem_words   = 64;
	localparam int cycle_limit = 6000;   // seven short programs of a few hundred cycles each

	logic        clk;
	logic        rst;
	logic        reset_req = 1'b0;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready = 1'b0;
	logic [31:0] rdata = 32'd0;
	logic [1:0]  rresp = 2'd0;
	logic        rvalid = 1'b0;
	logic        rready;
	logic        halted;
	logic        retire_valid;
	logic [4:0]  retire_rd;
	logic [31:0] retire_data;

	logic [31:0] mem [0:mem_words-1];
	logic [31:0] raddr = 32'd0;
	logic        pending = 1'b0;
	int unsigned ar_cnt = 0;
	int unsigned r_cnt = 0;
	int unsigned lcg_state = 85;
	int unsigned cycles = 0;
	bit          random_delays = 1'b0;
	logic        halted_q = 1'b0;
	logic        arvalid_q = 1'b0;
	logic [36:0] retired [$];   // {rd, data}
	logic [31:0] ar_seen [$];
	logic [36:0] exp_ret [$];
	logic [31:0] exp_ar [$];
	logic [31:0] prog [$];

	tb_clock i_clock (.reset_req, .clk, .rst);

	rv_core i_rv_core (
		.clk, .rst,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.halted, .retire_valid, .retire_rd, .retire_data
	);

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 1103515245 + 12345;
		return (lcg_state >> 16) & 32'h7fff;
	endfunction

	function automatic int unsigned pick_delay();
		return random_delays ? (lcg_next() % 4) : 0;
	endfunction

	// ------------------------------
	// instruction encoders
	// ------------------------------
	function automatic logic [31:0] enc_i(int imm, int rs1, int f3, int rd, int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] enc_u(int imm20, int rd, int opc);
		return {imm20[19:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] enc_j(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] enc_b(int off, int rs2, int rs1, int f3);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
	endfunction

	function automatic logic [36:0] wr(int rd, logic [31:0] data);
		return {rd[4:0], data};
	endfunction

	// ------------------------------
	// checks
	// ------------------------------
	task automatic fail(input string why);
		$display("Test FAILED");
		$display("%s", why);
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Test FAILED");
			$display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
			$fatal(1);
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit)
			fail("timeout, the core did not reach halt in time");
	end

	// AXI4-Lite read responder
	always @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			pending <= 1'b0;
			ar_cnt  <= pick_delay();
		end
		else
		begin
			if (arvalid && arready)
			begin
				arready <= 1'b0;
				pending <= 1'b1;
				raddr   <= araddr;
				r_cnt   <= pick_delay();
				ar_cnt  <= pick_delay();
			end
			else if (arvalid && !pending)
			begin
				if (ar_cnt == 0)
					arready <= 1'b1;
				else
					ar_cnt <= ar_cnt - 1;
			end
			if (pending && !rvalid)
			begin
				if (r_cnt == 0)
				begin
					rvalid <= 1'b1;
					if (raddr < mem_words * 4)
					begin
						rdata <= mem[raddr[7:2]];
						rresp <= 2'd0;
					end
					else
					begin
						rdata <= 32'h0050_0093;   // addi x1,x0,5 if not replaced
						rresp <= 2'd2;
					end
				end
				else
					r_cnt <= r_cnt - 1;
			end
			if (rvalid && rready)
			begin
				rvalid  <= 1'b0;
				pending <= 1'b0;
			end
		end
	end

	// retire and AR monitor
	always @(posedge clk)
	begin
		if (!rst)
		begin
			retired.delete();
			ar_seen.delete();
			halted_q  <= 1'b0;
			arvalid_q <= 1'b0;
		end
		else
		begin
			if (retire_valid)
				retired.push_back({retire_rd, retire_data});
			if (arvalid && arready)
				ar_seen.push_back(araddr);
			if (halted_q && retire_valid)
				fail("an instruction retired after the core halted");
			if (halted_q && arvalid && !arvalid_q)
				fail("a new read address was issued after the core halted");
			halted_q  <= halted;
			arvalid_q <= arvalid;
		end
	end

	// ------------------------------
	// test helpers
	// ------------------------------
	task automatic load_program();
		for (int i = 0; i < mem_words; i++)
			mem[i] = {i[11:0], 20'h00013};   // addi x0,x0,index
		foreach (prog[i])
			mem[i] = prog[i];
	endtask

	task automatic restart_dut();
		@(posedge clk);
		reset_req <= 1'b1;
		@(posedge clk);
		reset_req <= 1'b0;
		do
			@(posedge clk);
		while (!rst);
	endtask

	task automatic run_to_halt();
		while (!halted)
			@(posedge clk);
		while (arvalid || rready)
			@(posedge clk);   // let the last read finish
		@(posedge clk);
	endtask

	task automatic compare_retires();
		check("retire count", 32'(retired.size()), 32'(exp_ret.size()));
		foreach (exp_ret[i])
		begin
			check("retire_rd", {27'd0, retired[i][36:32]}, {27'd0, exp_ret[i][36:32]});
			check("retire_data", retired[i][31:0], exp_ret[i][31:0]);
		end
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic test_reset_state();
		prog = {32'h0000_0073};
		load_program();
		restart_dut();
		check("arvalid", {31'd0, arvalid}, 32'd1);
		check("araddr", araddr, 32'h0);
		check("halted", {31'd0, halted}, 32'd0);
		check("retire_valid", {31'd0, retire_valid}, 32'd0);
		run_to_halt();
		check("first ar address", ar_seen[0], 32'h0);
	endtask

	task automatic test_arith(input bit slow);
		random_delays = slow;
		prog = {enc_i(5, 0, 0, 1, 'h13), enc_i(-3, 1, 0, 2, 'h13),
			enc_r(0, 2, 1, 0, 3), enc_r('h20, 1, 2, 0, 4),
			enc_i(-16, 0, 0, 5, 'h13), enc_i('h402, 5, 5, 6, 'h13),
			enc_i(2, 5, 5, 7, 'h13), enc_i(3, 1, 1, 8, 'h13),
			enc_i(0, 5, 2, 9, 'h13), enc_i(-1, 1, 3, 10, 'h13),
			enc_i('hff, 1, 4, 11, 'h13), enc_i('h30, 1, 6, 12, 'h13),
			enc_i(3, 3, 7, 13, 'h13), enc_r('h20, 2, 5, 5, 14),
			enc_r(0, 2, 5, 5, 15), enc_r(0, 2, 1, 1, 16),
			enc_r(0, 1, 5, 2, 17), enc_r(0, 1, 5, 3, 18),
			enc_r(0, 3, 1, 4, 19), enc_r(0, 2, 1, 6, 20),
			enc_r(0, 4, 3, 7, 21), 32'h0000_0073};
		exp_ret = {wr(1, 5), wr(2, 2), wr(3, 7), wr(4, 32'hffff_fffd),
			wr(5, 32'hffff_fff0), wr(6, 32'hffff_fffc), wr(7, 32'h3fff_fffc),
			wr(8, 32'h28), wr(9, 1), wr(10, 1), wr(11, 32'hfa), wr(12, 32'h35),
			wr(13, 3), wr(14, 32'hffff_fffc), wr(15, 32'h3fff_fffc), wr(16, 32'h14),
			wr(17, 1), wr(18, 0), wr(19, 2), wr(20, 7), wr(21, 5)};
		load_program();
		restart_dut();
		run_to_halt();
		compare_retires();
		random_delays = 1'b0;
	endtask

	task automatic test_upper();
		// the last lui has x1 in its rs1 bits
		prog = {enc_u('h12345, 1, 'h37), enc_u('h1, 2, 'h17), enc_u('habcde, 0, 'h37),
			enc_u('hfffff, 3, 'h17), enc_i(1, 1, 0, 0, 'h13),
			enc_i('h678, 1, 0, 4, 'h13), enc_u('h8, 5, 'h37), 32'h0000_0073};
		exp_ret = {wr(1, 32'h1234_5000), wr(2, 32'h1004), wr(3, 32'hffff_f00c),
			wr(4, 32'h1234_5678), wr(5, 32'h8000)};
		load_program();
		restart_dut();
		run_to_halt();
		compare_retires();
	endtask

	task automatic test_branches();
		prog = {enc_i(3, 0, 0, 1, 'h13), enc_i(3, 0, 0, 2, 'h13),
			enc_b(12, 2, 1, 0), enc_i(1, 0, 0, 5, 'h13),
			enc_i(2, 0, 0, 5, 'h13), enc_b(8, 2, 1, 1),
			enc_b(8, 1, 0, 4), enc_i(9, 0, 0, 6, 'h13),
			enc_j(12, 7), enc_i(1, 0, 0, 8, 'h13),
			32'h0000_0073, enc_i('h38, 0, 0, 9, 'h13),
			enc_i(1, 9, 0, 10, 'h67), enc_i(7, 0, 0, 11, 'h13),
			enc_b(-16, 0, 1, 7)};
		exp_ret = {wr(1, 3), wr(2, 3), wr(7, 32'h24), wr(9, 32'h38), wr(10, 32'h34)};
		// each taken redirect costs one wrong-path fetch
		exp_ar = {32'h00, 32'h04, 32'h08, 32'h0c, 32'h14, 32'h18, 32'h1c, 32'h20,
			32'h24, 32'h2c, 32'h30, 32'h34, 32'h38, 32'h3c, 32'h28, 32'h2c};
		load_program();
		restart_dut();
		run_to_halt();
		compare_retires();
		check("ar count", 32'(ar_seen.size()), 32'(exp_ar.size()));
		foreach (exp_ar[i])
			check("araddr", ar_seen[i], exp_ar[i]);
	endtask

	task automatic test_halt();
		prog = {enc_i(1, 0, 0, 1, 'h13), 32'h0000_000b,
			enc_i(2, 0, 0, 2, 'h13), enc_i(3, 0, 0, 3, 'h13)};
		exp_ret = {wr(1, 1)};
		load_program();
		restart_dut();
		run_to_halt();
		compare_retires();

		// jump past the end of memory so the read errors
		prog = {enc_i(4, 0, 0, 1, 'h13), enc_j('h3fc, 0), enc_i(6, 0, 0, 2, 'h13)};
		exp_ret = {wr(1, 4)};
		load_program();
		restart_dut();
		run_to_halt();
		compare_retires();
		check("last araddr", ar_seen[ar_seen.size() - 1], 32'h404);
	endtask

	initial
	begin
		test_reset_state();
		test_arith(1'b0);
		test_upper();
		test_branches();
		test_arith(1'b1);
		test_halt();
		$display("Test OK");
		$finish;
	end

endmodule
